//--- src.f
+incdir+include
src/bcfg_pkg.sv
src/board_detect.sv
src/prom_spi.sv
src/io_sampler.sv
src/bcfg_regs.sv
src/boot_config.sv
sim/prom_model.sv
sim/tb_boot_config.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the boot configuration testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f \
        --top-module tb_boot_config -o tb_boot_config > build.log 2>&1; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_boot_config > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1

//--- sim/tb_boot_config.sv
/* Boot configuration testbench */

`timescale 1ns/10ps

`include "bcfg_macros.svh"

module tb_boot_config;

    localparam int TIMEOUT_CYCLES = 20000;

    logic        sysclk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [3:0]  board_id;
    logic        is_v30;
    logic [0:33] io1;
    logic [0:39] io2;
    logic        prom_sclk;
    logic        prom_mosi;
    logic        prom_cs_n;
    logic        prom_miso;
    logic        sample_start;
    logic        sample_busy;
    logic [31:0] timestamp;
    logic [7:0]  model_edges;

    int          cycle_count;
    int          cs_falls;
    int          cs_rises;
    logic [31:0] rd;
    logic [8:0]  fl;
    logic [15:0] prom_addr;
    int          polls;
    int          gap;
    int          diff;

    boot_config u_boot_config (
        .sysclk       (sysclk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .board_id     (board_id),
        .is_v30       (is_v30),
        .io1          (io1),
        .io2          (io2),
        .prom_sclk    (prom_sclk),
        .prom_mosi    (prom_mosi),
        .prom_cs_n    (prom_cs_n),
        .prom_miso    (prom_miso),
        .sample_start (sample_start),
        .sample_busy  (sample_busy),
        .timestamp    (timestamp)
    );

    prom_model u_prom_model (
        .sclk       (prom_sclk),
        .mosi       (prom_mosi),
        .cs_n       (prom_cs_n),
        .miso       (prom_miso),
        .edge_count (model_edges)
    );

    // 4 ns period
    always #2 sysclk = ~sysclk;

    // ------------------------------------------------------------------------
    // Failure reporting and run limit
    // ------------------------------------------------------------------------

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
    endtask

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("Timeout, the run did not finish within the cycle limit");
        end
    end

    always @(negedge prom_cs_n) cs_falls++;
    always @(posedge prom_cs_n) if (!reset) cs_rises++;

    // Ack one cycle after a new strobe, and never two in a row
    assert property (@(posedge sysclk) disable iff (reset)
                     (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else report_failure("Bus strobe was not acknowledged on the next cycle");
    assert property (@(posedge sysclk) disable iff (reset) wb_ack |=> !wb_ack)
        else report_failure("Ack stayed high for more than one cycle");

    // ------------------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------------------

    task automatic wb_access(input logic we, input logic [15:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        @(negedge sysclk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        do begin
            @(negedge sysclk);
            waited++;
        end while (!wb_ack && waited < 8);
        assert (wb_ack && waited == 1) else
            report_failure("Bus access was not acknowledged one cycle after strobe");
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    // ------------------------------------------------------------------------
    // Reference detection rules
    // ------------------------------------------------------------------------

    // Order: none, qla, dqla, drac, then the five partial terms
    function automatic logic [8:0] expected_flags(input logic [0:33] p1,
                                                  input logic [0:39] p2);
        logic none_f;
        logic qz;
        logic dz;
        logic d1;
        logic rz;
        logic r1;
        none_f = (&p1) && (&p2);
        qz = !(p1[0] || p1[31] || p1[32] || p2[1] || p2[3] || p2[5] || p2[7] ||
               p2[11] || (|p2[31:38]));
        dz = !p1[0];
        d1 = p1[12] && p1[31];
        rz = !(p1[9] || p1[12] || p1[19] || p1[21] || p1[23] || p1[32] ||
               p2[10] || p2[15] || p2[22] || p2[28] || p2[29] || p2[34]);
        r1 = p2[1] && p2[3] && p2[5] && p2[31] && p2[32] && p2[33] &&
             p2[35] && p2[36];
        return {none_f, qz, dz && d1, rz && r1, qz, dz, d1, rz, r1};
    endfunction

    task automatic randomize_pins();
        io1      = 34'({$urandom(), $urandom()});
        io2      = 40'({$urandom(), $urandom()});
        board_id = 4'($urandom());
        is_v30   = 1'($urandom());
    endtask

    // Apply pins, let the detector settle, check the status word
    task automatic check_status(input string what);
        logic [8:0] f;
        @(negedge sysclk);
        @(negedge sysclk);
        f = expected_flags(io1, io2);
        wb_read({`BCFG_ADDR_MAIN, 8'h00, `BCFG_REG_STATUS}, rd);
        check_equal(what, rd, {4'd0, board_id, f[8:5], is_v30, f[4:0], 13'd0, 1'b0});
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(32'hb05dafc4));
        sysclk       = 1'b0;
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        board_id     = '0;
        is_v30       = 1'b0;
        io1          = '1;
        io2          = '1;
        sample_start = 1'b0;
        cycle_count  = 0;
        cs_falls     = 0;
        cs_rises     = 0;
        repeat (10) @(negedge sysclk);
        reset = 1'b0;
        @(negedge sysclk);

        // Reset state
        check_equal("prom_cs_n after reset", 32'(prom_cs_n), 32'd1);
        check_equal("prom_sclk after reset", 32'(prom_sclk), 32'd0);
        check_equal("sample_busy after reset", 32'(sample_busy), 32'd0);
        check_equal("timestamp after reset", timestamp, 32'd0);

        // Version, read-only write, unmapped reads
        wb_write({`BCFG_ADDR_MAIN, 8'h00, `BCFG_REG_VERSION}, 32'h12345678);
        wb_read({`BCFG_ADDR_MAIN, 8'h00, `BCFG_REG_VERSION}, rd);
        check_equal("version", rd, `BCFG_VERSION);
        wb_read(16'h3000, rd);
        check_equal("unmapped space 3", rd, 32'd0);
        wb_read(16'hF001, rd);
        check_equal("unmapped space F", rd, 32'd0);
        wb_read(16'h0005, rd);
        check_equal("unmapped main offset", rd, 32'd0);
        wb_read(16'h2004, rd);
        check_equal("unmapped sample offset", rd, 32'd0);

        // Board detection, empty connector first
        check_status("status all ones");
        randomize_pins();
        {io1[0], io1[31], io1[32], io2[1], io2[3], io2[5], io2[7], io2[11]} = '0;
        io2[31:38] = '0;
        check_status("status QLA");
        randomize_pins();
        io1[0]  = 1'b0;
        io1[12] = 1'b1;
        io1[31] = 1'b1;
        check_status("status DQLA");
        randomize_pins();
        {io1[9], io1[12], io1[19], io1[21], io1[23], io1[32]} = '0;
        {io2[10], io2[15], io2[22], io2[28], io2[29], io2[34]} = '0;
        {io2[1], io2[3], io2[5], io2[31], io2[32], io2[33], io2[35], io2[36]} = '1;
        check_status("status DRAC");
        for (int i = 0; i < 20; i++) begin
            randomize_pins();
            check_status($sformatf("status random %0d", i));
        end

        // EEPROM read, second command sent while busy
        prom_addr = 16'($urandom());
        wb_write({`BCFG_ADDR_PROM, 8'h00, `BCFG_PROM_CMD}, {8'h03, prom_addr, 8'h00});
        wb_read({`BCFG_ADDR_MAIN, 8'h00, `BCFG_REG_STATUS}, rd);
        check_equal("prom_busy after command", 32'(rd[0]), 32'd1);
        wb_write({`BCFG_ADDR_PROM, 8'h00, `BCFG_PROM_CMD},
                 {8'h03, prom_addr ^ 16'h00FF, 8'h00});
        polls = 0;
        do begin
            wb_read({`BCFG_ADDR_MAIN, 8'h00, `BCFG_REG_STATUS}, rd);
            polls++;
        end while (rd[0] && polls < 200);
        assert (!rd[0]) else report_failure("EEPROM transfer never finished");
        repeat (4) @(negedge sysclk);
        wb_read({`BCFG_ADDR_PROM, 8'h00, `BCFG_PROM_RESULT}, rd);
        check_equal("EEPROM result", rd, {24'd0, prom_addr[7:0] ^ 8'hA5});
        check_equal("sclk rising edges in frame", 32'(model_edges), 32'd32);
        check_equal("chip select falls", 32'(cs_falls), 32'd1);
        check_equal("chip select rises", 32'(cs_rises), 32'd1);

        // Pin snapshot
        randomize_pins();
        @(negedge sysclk);
        @(negedge sysclk);
        fl = expected_flags(io1, io2);
        sample_start = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(negedge sysclk);
            check_equal("sample_busy while start held", 32'(sample_busy), 32'd1);
        end
        sample_start = 1'b0;
        @(negedge sysclk);
        check_equal("sample_busy after release", 32'(sample_busy), 32'd0);
        wb_read({`BCFG_ADDR_SAMPLE, 12'h001}, rd);
        check_equal("sample word 1", rd, {board_id, fl, 9'd0, io1[0:9]});
        wb_read({`BCFG_ADDR_SAMPLE, 12'h002}, rd);
        check_equal("sample word 2", rd, {io1[10:33], io2[0:7]});
        wb_read({`BCFG_ADDR_SAMPLE, 12'h003}, rd);
        check_equal("sample word 3", rd, io2[8:39]);

        // Timestamp between two accepted samples
        gap = 30 + int'($urandom() % 40);
        sample_start = 1'b1;
        @(negedge sysclk);
        sample_start = 1'b0;
        repeat (gap - 1) @(negedge sysclk);
        sample_start = 1'b1;
        @(negedge sysclk);
        check_equal("timestamp restart", timestamp, 32'd0);
        check_equal("sample_busy second start", 32'(sample_busy), 32'd1);
        sample_start = 1'b0;
        wb_read({`BCFG_ADDR_SAMPLE, 12'h000}, rd);
        // One count every other cycle
        diff = int'(rd) - gap / 2;
        assert (diff >= -1 && diff <= 1) else
            report_failure($sformatf("Mismatch at %0t: timestamp %0d for a %0d cycle gap",
                                     $time, rd, gap));

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- sim/prom_model.sv
/* 25AA128 EEPROM model */

`timescale 1ns/10ps

module prom_model (
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    output logic       miso,
    // Rising edges seen in the last completed frame
    output logic [7:0] edge_count
);

    logic [5:0]  bit_count;
    logic [31:0] frame;
    logic [7:0]  reply;

    initial begin
        bit_count  = '0;
        frame      = '0;
        reply      = '0;
        miso       = 1'b0;
        edge_count = '0;
    end

    // ------------------------------------------------------------------------
    // Frame capture, opcode then address then dummy byte
    // ------------------------------------------------------------------------

    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            // End of frame
            if (bit_count != 6'd0) begin
                edge_count <= {2'b00, bit_count};
            end
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 6'd1;
            frame     <= {frame[30:0], mosi};
            // Address low byte complete after 24 bits
            if (bit_count == 6'd23) begin
                reply <= {frame[6:0], mosi} ^ 8'hA5;
            end
        end
    end

    // Reply shifted out during the last 8 bits
    always @(negedge sclk or negedge cs_n) begin
        if (!cs_n && bit_count >= 6'd24 && bit_count <= 6'd31) begin
            miso <= reply[3'(6'd31 - bit_count)];
        end else begin
            miso <= 1'b0;
        end
    end

endmodule

//--- src/boot_config.sv
/* Boot configuration top level */

`timescale 1ns/10ps

module boot_config import bcfg_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    // Host bus
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [15:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    // Rotary switch and FPGA revision
    input  logic [3:0]  board_id,
    input  logic        is_v30,
    // Connector pins
    input  logic [0:33] io1,
    input  logic [0:39] io2,
    // Board EEPROM
    output logic        prom_sclk,
    output logic        prom_mosi,
    output logic        prom_cs_n,
    input  logic        prom_miso,
    // Sampling
    input  logic        sample_start,
    output logic        sample_busy,
    output logic [31:0] timestamp
);

    detect_flags_t flags;
    logic          prom_wr;
    logic [31:0]   prom_cmd;
    logic [31:0]   prom_result;
    logic          prom_busy;
    logic [1:0]    buffer_index;
    logic [31:0]   buffer_word;

    board_detect u_board_detect (
        .sysclk (sysclk),
        .reset  (reset),
        .io1    (io1),
        .io2    (io2),
        .flags  (flags)
    );

    prom_spi u_prom_spi (
        .sysclk    (sysclk),
        .reset     (reset),
        .cmd_wr    (prom_wr),
        .cmd       (prom_cmd),
        .result    (prom_result),
        .busy      (prom_busy),
        .prom_sclk (prom_sclk),
        .prom_mosi (prom_mosi),
        .prom_cs_n (prom_cs_n),
        .prom_miso (prom_miso)
    );

    io_sampler u_io_sampler (
        .sysclk       (sysclk),
        .reset        (reset),
        .sample_start (sample_start),
        .io1          (io1),
        .io2          (io2),
        .flags        (flags),
        .board_id     (board_id),
        .sample_busy  (sample_busy),
        .timestamp    (timestamp),
        .buffer_index (buffer_index),
        .buffer_word  (buffer_word)
    );

    bcfg_regs u_bcfg_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .flags        (flags),
        .board_id     (board_id),
        .is_v30       (is_v30),
        .prom_result  (prom_result),
        .prom_busy    (prom_busy),
        .prom_wr      (prom_wr),
        .prom_cmd     (prom_cmd),
        .buffer_index (buffer_index),
        .buffer_word  (buffer_word)
    );

endmodule

//--- src/bcfg_regs.sv
/* Wishbone register slave */

`timescale 1ns/10ps

`include "bcfg_macros.svh"

module bcfg_regs import bcfg_pkg::*; (
    input  logic          sysclk,
    input  logic          reset,
    // Wishbone classic slave
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  logic [15:0]   wb_adr,
    input  logic [31:0]   wb_dat_w,
    output logic [31:0]   wb_dat_r,
    output logic          wb_ack,
    // Board status
    input  detect_flags_t flags,
    input  logic [3:0]    board_id,
    input  logic          is_v30,
    // EEPROM engine
    input  logic [31:0]   prom_result,
    input  logic          prom_busy,
    output logic          prom_wr,
    output logic [31:0]   prom_cmd,
    // Sample buffer
    output logic [1:0]    buffer_index,
    input  logic [31:0]   buffer_word
);

    logic        req;
    logic        cmd_hit;
    logic [3:0]  space;
    logic [3:0]  offset;
    logic [31:0] status_word;
    logic [31:0] rd_mux;

    // New access, not yet acknowledged
    assign req    = wb_cyc & wb_stb & ~wb_ack;
    assign space  = wb_adr[15:12];
    assign offset = wb_adr[3:0];
    assign cmd_hit = req && wb_we && (space == `BCFG_ADDR_PROM) &&
                     (offset == `BCFG_PROM_CMD);

    assign buffer_index = wb_adr[1:0];

    // Status layout, busy in bit 0
    assign status_word = {4'd0, board_id,
                          flags.is_none, flags.is_qla, flags.is_dqla, flags.is_drac,
                          is_v30,
                          flags.qla_zeros, flags.dqla_zeros, flags.dqla_ones,
                          flags.drac_zeros, flags.drac_ones,
                          13'd0, prom_busy};

    // ------------------------------------------------------------------------
    // Read mux, unmapped reads as zero
    // ------------------------------------------------------------------------

    always_comb begin
        rd_mux = 32'd0;
        case (space)
            `BCFG_ADDR_MAIN: begin
                if (offset == `BCFG_REG_STATUS) begin
                    rd_mux = status_word;
                end else if (offset == `BCFG_REG_VERSION) begin
                    rd_mux = `BCFG_VERSION;
                end
            end
            `BCFG_ADDR_PROM: begin
                if (offset == `BCFG_PROM_RESULT) begin
                    rd_mux = prom_result;
                end
            end
            `BCFG_ADDR_SAMPLE: begin
                // Four words only
                if (offset[3:2] == 2'd0) begin
                    rd_mux = buffer_word;
                end
            end
            default: rd_mux = 32'd0;
        endcase
    end

    // Ack and read data one cycle after strobe
    always_ff @(posedge sysclk) begin
        if (reset) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            prom_wr  <= 1'b0;
        end else begin
            wb_ack   <= req;
            wb_dat_r <= req ? rd_mux : 32'd0;
            prom_wr  <= cmd_hit;
        end
    end

    // Command word, valid alongside prom_wr
    always_ff @(posedge sysclk) begin
        if (cmd_hit) begin
            prom_cmd <= wb_dat_w;
        end
    end

endmodule

//--- src/io_sampler.sv
/* Connector pin sampler */

`timescale 1ns/10ps

module io_sampler import bcfg_pkg::*; (
    input  logic          sysclk,
    input  logic          reset,
    input  logic          sample_start,
    input  logic [0:33]   io1,
    input  logic [0:39]   io2,
    input  detect_flags_t flags,
    input  logic [3:0]    board_id,
    output logic          sample_busy,
    output logic [31:0]   timestamp,
    // Buffer read port
    input  logic [1:0]    buffer_index,
    output logic [31:0]   buffer_word
);

    logic [31:0] snap_buf [0:3];
    logic        ts_phase;
    logic        accept;

    // Start only counts when not already sampling
    assign accept = sample_start & ~sample_busy;

    assign buffer_word = snap_buf[buffer_index];

    // ------------------------------------------------------------------------
    // Timestamp and snapshot capture
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            sample_busy <= 1'b0;
            timestamp   <= '0;
            ts_phase    <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                snap_buf[i] <= '0;
            end
        end else begin
            // Held while start stays high
            sample_busy <= sample_start;
            if (accept) begin
                // Old count goes into word 0, then restart
                snap_buf[0] <= timestamp;
                snap_buf[1] <= {board_id, flags, 9'd0, io1[0:9]};
                snap_buf[2] <= {io1[10:33], io2[0:7]};
                snap_buf[3] <= io2[8:39];
                timestamp   <= '0;
                ts_phase    <= 1'b0;
            end else begin
                // One count every other cycle
                ts_phase <= ~ts_phase;
                if (ts_phase) begin
                    timestamp <= timestamp + 32'd1;
                end
            end
        end
    end

endmodule

//--- src/prom_spi.sv
/* EEPROM SPI master */

`timescale 1ns/10ps

`include "bcfg_macros.svh"

module prom_spi (
    input  logic        sysclk,
    input  logic        reset,
    // Command from register block
    input  logic        cmd_wr,
    input  logic [31:0] cmd,
    output logic [31:0] result,
    output logic        busy,
    // 25AA128 pins
    output logic        prom_sclk,
    output logic        prom_mosi,
    output logic        prom_cs_n,
    input  logic        prom_miso
);

    // Last count of the half-period divider
    localparam logic [7:0] DIV_LAST = 8'(`BCFG_SPI_DIV - 1);

    logic [7:0]  div_cnt;
    logic [4:0]  bit_cnt;
    logic [31:0] shift_reg;
    logic        last_bit;
    logic        tick;

    // Half SPI clock elapsed
    assign tick = busy && (div_cnt == DIV_LAST);

    // MSB first
    assign prom_mosi = shift_reg[31];

    // ------------------------------------------------------------------------
    // Transfer sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            busy      <= 1'b0;
            prom_cs_n <= 1'b1;
            prom_sclk <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            last_bit  <= 1'b0;
            shift_reg <= '0;
            result    <= '0;
        end else if (!busy) begin
            // New command only accepted when idle
            if (cmd_wr) begin
                busy      <= 1'b1;
                prom_cs_n <= 1'b0;
                div_cnt   <= '0;
                bit_cnt   <= '0;
                last_bit  <= 1'b0;
                shift_reg <= cmd;
            end
        end else if (!tick) begin
            div_cnt <= div_cnt + 8'd1;
        end else begin
            div_cnt <= '0;
            if (last_bit) begin
                // Tail half period, then release the chip
                prom_sclk <= 1'b0;
                prom_cs_n <= 1'b1;
                busy      <= 1'b0;
            end else if (!prom_sclk) begin
                // Rising edge, capture MISO
                prom_sclk <= 1'b1;
                result    <= {result[30:0], prom_miso};
                last_bit  <= (bit_cnt == 5'd31);
            end else begin
                // Falling edge, present next MOSI bit
                prom_sclk <= 1'b0;
                shift_reg <= {shift_reg[30:0], 1'b0};
                bit_cnt   <= bit_cnt + 5'd1;
            end
        end
    end

endmodule

//--- src/board_detect.sv
/* Analog board detector */

`timescale 1ns/10ps

module board_detect import bcfg_pkg::*; (
    input  logic          sysclk,
    input  logic          reset,
    // Connector pins with pull-ups, sampled as plain inputs
    input  logic [0:33]   io1,
    input  logic [0:39]   io2,
    // Registered classification
    output detect_flags_t flags
);

    detect_flags_t flags_next;

    // ------------------------------------------------------------------------
    // Classification rules
    // ------------------------------------------------------------------------

    // Only bits that separate the boards are checked
    always_comb begin
        // Empty connector, every pin pulled high
        flags_next.is_none = (io1 == {34{1'b1}}) && (io2 == {40{1'b1}});

        // QLA zeros alone are enough
        // IO1[31] is high on DQLA, many pins are high on DRAC and NONE
        flags_next.qla_zeros = ~(io1[0] | io1[31] | io1[32] |
                                 io2[1] | io2[3] | io2[5] | io2[7] | io2[11] |
                                 io2[31] | io2[32] | io2[33] | io2[34] |
                                 io2[35] | io2[36] | io2[37] | io2[38]);
        flags_next.is_qla = flags_next.qla_zeros;

        // DQLA
        // IO1[0] high on NONE
        flags_next.dqla_zeros = ~io1[0];
        // IO1[12] low on DRAC, IO1[31] low on QLA
        flags_next.dqla_ones = io1[12] & io1[31];
        flags_next.is_dqla = flags_next.dqla_zeros & flags_next.dqla_ones;

        // DRAC
        // IO1[12] high on DQLA
        flags_next.drac_zeros = ~(io1[9] | io1[12] | io1[19] | io1[21] |
                                  io1[23] | io1[32] |
                                  io2[10] | io2[15] | io2[22] | io2[28] |
                                  io2[29] | io2[34]);
        // These are low on QLA
        flags_next.drac_ones = io2[1] & io2[3] & io2[5] & io2[31] &
                               io2[32] & io2[33] & io2[35] & io2[36];
        flags_next.is_drac = flags_next.drac_zeros & flags_next.drac_ones;
    end

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // One cycle behind the pins
    always_ff @(posedge sysclk) begin
        if (reset) begin
            flags <= '0;
        end else begin
            flags <= flags_next;
        end
    end

endmodule

//--- src/bcfg_pkg.sv
/* Boot configuration types */

package bcfg_pkg;

    // ------------------------------------------------------------------------
    // Board kinds
    // ------------------------------------------------------------------------

    // No match is seen as all four is_* flags low
    typedef enum logic [1:0] {
        NONE = 2'd0,
        QLA  = 2'd1,
        DQLA = 2'd2,
        DRAC = 2'd3
    } board_kind_t;

    // ------------------------------------------------------------------------
    // Detector result flags
    // ------------------------------------------------------------------------

    // Field order matches status word bits 23:20 then 18:14
    typedef struct packed {
        // Final classification
        logic is_none;
        logic is_qla;
        logic is_dqla;
        logic is_drac;
        // Partial terms
        logic qla_zeros;
        logic dqla_zeros;
        logic dqla_ones;
        logic drac_zeros;
        logic drac_ones;
    } detect_flags_t;

endpackage

//--- include/bcfg_macros.svh
/* Boot configuration constants */

`ifndef BCFG_MACROS_SVH
`define BCFG_MACROS_SVH

// ----------------------------------------------------------------------------
// Address spaces, selected by address bits 15:12
// ----------------------------------------------------------------------------

// Board status and version registers
`define BCFG_ADDR_MAIN      4'h0
// 25AA128 EEPROM command and reply
`define BCFG_ADDR_PROM      4'h1
// Pin snapshot buffer
`define BCFG_ADDR_SAMPLE    4'h2

// ----------------------------------------------------------------------------
// Register offsets, address bits 3:0
// ----------------------------------------------------------------------------

// Main space
`define BCFG_REG_STATUS     4'h0
`define BCFG_REG_VERSION    4'h1

// EEPROM space
`define BCFG_PROM_CMD       4'h0
`define BCFG_PROM_RESULT    4'h1

// ----------------------------------------------------------------------------
// Misc constants
// ----------------------------------------------------------------------------

// ASCII "BCFG"
`define BCFG_VERSION        32'h42434647

// Sysclk cycles per half SPI clock
`define BCFG_SPI_DIV        2

`endif
